// ==== vector_lane_unit.f ====
+incdir+hdl
hdl/vector_isa_pkg.sv
hdl/vector_exec_pkg.sv
hdl/vector_stage_if.sv
hdl/vector_decode.sv
hdl/vector_execute.sv
hdl/vector_result.sv
hdl/vector_lane_unit.sv
testbench/tb_vector_lane_unit.sv

// ==== testbench/tb_vector_lane_unit.sv ====
`default_nettype none
`include "vector_macros.svh"

module tb_vector_lane_unit;

  logic                      clk;
  logic                      reset;
  logic                      instr_valid;
  logic [`VLU_INSTR_W-1:0]   instr;
  logic [`VLU_XLEN-1:0]      vs1_data;
  logic [`VLU_XLEN-1:0]      vs2_data;
  logic [`VLU_XLEN-1:0]      rs1_data;
  logic                      result_credit;
  logic                      in_credit;
  logic                      result_valid;
  logic [`VLU_XLEN-1:0]      result_data;
  logic [`VLU_ELEMS_MAX-1:0] result_mask;
  logic [4:0]                result_vd;
  logic                      result_illegal;

  // expected beats as {illegal, vd, mask, data}
  logic [41:0] exp_q[$];
  string       name_q[$];
  logic [31:0] lfsr;
  int          up_credits;
  int          out_credits;
  int          shadow_code;
  logic        credit_on;

  logic [5:0] op_f6 [17] = '{vector_isa_pkg::F6_VADD, vector_isa_pkg::F6_VSUB,
    vector_isa_pkg::F6_VRSUB, vector_isa_pkg::F6_VAND, vector_isa_pkg::F6_VOR,
    vector_isa_pkg::F6_VXOR, vector_isa_pkg::F6_VMINU, vector_isa_pkg::F6_VMIN,
    vector_isa_pkg::F6_VMAXU, vector_isa_pkg::F6_VMAX, vector_isa_pkg::F6_VMSEQ,
    vector_isa_pkg::F6_VMSNE, vector_isa_pkg::F6_VMSLTU, vector_isa_pkg::F6_VMSLT,
    vector_isa_pkg::F6_VSLL, vector_isa_pkg::F6_VSRL, vector_isa_pkg::F6_VSRA};
  string op_names [17] = '{"vadd", "vsub", "vrsub", "vand", "vor", "vxor", "vminu", "vmin",
    "vmaxu", "vmax", "vmseq", "vmsne", "vmsltu", "vmslt", "vsll", "vsrl", "vsra"};
  logic [2:0] form_f3 [3] = '{vector_isa_pkg::OPIVV, vector_isa_pkg::OPIVX,
    vector_isa_pkg::OPIVI};
  string form_names [3] = '{"vv", "vx", "vi"};

  vector_lane_unit dut (
    .clk            (clk),
    .reset          (reset),
    .instr_valid    (instr_valid),
    .instr          (instr),
    .vs1_data       (vs1_data),
    .vs2_data       (vs2_data),
    .rs1_data       (rs1_data),
    .result_credit  (result_credit),
    .in_credit      (in_credit),
    .result_valid   (result_valid),
    .result_data    (result_data),
    .result_mask    (result_mask),
    .result_vd      (result_vd),
    .result_illegal (result_illegal)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic report_failure(input string what);
    $display("FAILURE: %s", what);
    $display("Checks failed");
    $fatal(1);
  endtask

  task automatic check_value(input string test, input string field,
                             input logic [31:0] expected, input logic [31:0] actual);
    assert (actual === expected) else begin
      $display("ERROR %s %s expected %0h actual %0h", test, field, expected, actual);
      $display("Checks failed");
      $fatal(1);
    end
  endtask

  // fibonacci lfsr with taps 32 22 2 1 and one step per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic fb;
    rand_bits = '0;
    for (int k = 0; k < n; k++) begin
      fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      rand_bits = {rand_bits[30:0], fb};
    end
  endfunction

  function automatic logic form_legal(input logic [5:0] f6, input logic [2:0] f3);
    case (f6)
      vector_isa_pkg::F6_VADD, vector_isa_pkg::F6_VAND, vector_isa_pkg::F6_VOR,
      vector_isa_pkg::F6_VXOR, vector_isa_pkg::F6_VMSEQ, vector_isa_pkg::F6_VMSNE,
      vector_isa_pkg::F6_VSLL, vector_isa_pkg::F6_VSRL, vector_isa_pkg::F6_VSRA:
        form_legal = f3 inside {vector_isa_pkg::OPIVV, vector_isa_pkg::OPIVX,
                                vector_isa_pkg::OPIVI};
      vector_isa_pkg::F6_VSUB, vector_isa_pkg::F6_VMINU, vector_isa_pkg::F6_VMIN,
      vector_isa_pkg::F6_VMAXU, vector_isa_pkg::F6_VMAX, vector_isa_pkg::F6_VMSLTU,
      vector_isa_pkg::F6_VMSLT:
        form_legal = f3 inside {vector_isa_pkg::OPIVV, vector_isa_pkg::OPIVX};
      vector_isa_pkg::F6_VRSUB:
        form_legal = f3 inside {vector_isa_pkg::OPIVX, vector_isa_pkg::OPIVI};
      default: form_legal = 1'b0;
    endcase
  endfunction

  // reference model that also keeps the vtype shadow
  function automatic logic [41:0] predict(input logic [31:0] word, input logic [31:0] v1,
                                          input logic [31:0] v2, input logic [31:0] r1);
    vector_isa_pkg::vinstr_u w;
    logic [3:0] m;
    int         sew;
    longint     emask, sbit, a, b, sa, sb, r, imm, sh, d;
    w = word;
    m = '0;
    d = 0;
    sew = 8 << shadow_code;
    if (w.arith.opcode != vector_isa_pkg::OP_VECTOR) return {1'b1, w.arith.vd, 36'h0};
    if (w.arith.funct3 == vector_isa_pkg::OPCFG) begin
      if (!w.cfg.sel && w.cfg.zimm11[5:3] <= 3'd2) begin
        shadow_code = int'(w.cfg.zimm11[5:3]);
        return {1'b0, w.arith.vd, 4'h0, 32'(shadow_code)};
      end
      return {1'b1, w.arith.vd, 36'h0};
    end
    if (!w.arith.vm || !form_legal(w.arith.funct6, w.arith.funct3)) begin
      return {1'b1, w.arith.vd, 36'h0};
    end
    emask = (longint'(1) << sew) - 1;
    sbit = longint'(1) << (sew - 1);
    imm = longint'(w.arith.vs1);
    // immediate is signed except for shifts
    if (!(w.arith.funct6 inside {vector_isa_pkg::F6_VSLL, vector_isa_pkg::F6_VSRL,
                                 vector_isa_pkg::F6_VSRA}) && imm >= 16) begin
      imm = imm - 32;
    end
    for (int i = 0; i < 32 / sew; i++) begin
      if (w.arith.funct3 == vector_isa_pkg::OPIVV) a = longint'(v1 >> (i * sew));
      else if (w.arith.funct3 == vector_isa_pkg::OPIVX) a = longint'(r1);
      else a = imm;
      a = a & emask;
      b = longint'(v2 >> (i * sew)) & emask;
      sa = (a ^ sbit) - sbit;
      sb = (b ^ sbit) - sbit;
      sh = a & (sew - 1);
      r = 0;
      case (w.arith.funct6)
        vector_isa_pkg::F6_VADD:   r = b + a;
        vector_isa_pkg::F6_VSUB:   r = b - a;
        vector_isa_pkg::F6_VRSUB:  r = a - b;
        vector_isa_pkg::F6_VAND:   r = b & a;
        vector_isa_pkg::F6_VOR:    r = b | a;
        vector_isa_pkg::F6_VXOR:   r = b ^ a;
        vector_isa_pkg::F6_VMINU:  r = (a < b) ? a : b;
        vector_isa_pkg::F6_VMIN:   r = (sa < sb) ? sa : sb;
        vector_isa_pkg::F6_VMAXU:  r = (a > b) ? a : b;
        vector_isa_pkg::F6_VMAX:   r = (sa > sb) ? sa : sb;
        vector_isa_pkg::F6_VMSEQ:  m[i] = (a == b);
        vector_isa_pkg::F6_VMSNE:  m[i] = (a != b);
        vector_isa_pkg::F6_VMSLTU: m[i] = (b < a);
        vector_isa_pkg::F6_VMSLT:  m[i] = (sb < sa);
        vector_isa_pkg::F6_VSLL:   r = b << sh;
        vector_isa_pkg::F6_VSRL:   r = b >> sh;
        default:                   r = sb >>> sh;
      endcase
      d = d | ((r & emask) << (i * sew));
    end
    return {1'b0, w.arith.vd, m, 32'(d)};
  endfunction

  function automatic logic [31:0] arith_word(input logic [5:0] f6, input logic vm,
                                             input logic [2:0] f3, input logic [4:0] vs1);
    vector_isa_pkg::vinstr_u w;
    w.arith.funct6 = f6;
    w.arith.vm = vm;
    w.arith.vs2 = rand_bits(5);
    w.arith.vs1 = vs1;
    w.arith.funct3 = f3;
    w.arith.vd = rand_bits(5);
    w.arith.opcode = vector_isa_pkg::OP_VECTOR;
    return w;
  endfunction

  // vsetvli with vsew in zimm[5:3] or the vsetvl form when sel is set
  function automatic logic [31:0] cfg_word(input logic sel, input logic [2:0] vsew);
    return {sel, 5'b0, vsew, 3'b0, 5'b0, vector_isa_pkg::OPCFG, 5'(rand_bits(5)),
            vector_isa_pkg::OP_VECTOR};
  endfunction

  // downstream models eight free slots
  task automatic tick();
    @(posedge clk);
    #1;
    result_credit = credit_on && (out_credits < 8) && (rand_bits(1) != 0);
  endtask

  task automatic run_op(input string name, input logic [31:0] word);
    int          waited;
    logic [31:0] v1, v2, r1;
    logic [1:0]  mode;
    waited = 0;
    v2 = rand_bits(32);
    v1 = rand_bits(32);
    r1 = rand_bits(32);
    mode = rand_bits(2);
    // equal operands now and then so the compares can match
    if (mode == 2'd0) v1 = v2;
    if (mode == 2'd1) r1 = v2;
    while (up_credits == 0) begin
      tick();
      waited++;
      assert (waited < 200) else report_failure("no input credit came back in 200 cycles");
    end
    instr_valid = 1'b1;
    instr = word;
    vs1_data = v1;
    vs2_data = v2;
    rs1_data = r1;
    up_credits--;
    exp_q.push_back(predict(word, v1, v2, r1));
    name_q.push_back(name);
    tick();
    instr_valid = 1'b0;
  endtask

  task automatic drain();
    int waited;
    waited = 0;
    while (exp_q.size() != 0) begin
      tick();
      waited++;
      assert (waited < 500) else report_failure("results stopped before the last one came out");
    end
  endtask

  // outputs sampled mid-cycle
  always @(negedge clk) begin : monitor
    logic [41:0] beat;
    string       name;
    if (reset) begin
      out_credits = 0;
    end else begin
      assert (in_credit == result_valid) else
        report_failure("in_credit did not match result_valid");
      if (result_valid) begin
        assert (out_credits > 0 || result_credit) else
          report_failure("result_valid went high without an output credit");
        assert (exp_q.size() > 0) else report_failure("result_valid with nothing outstanding");
        beat = exp_q.pop_front();
        name = name_q.pop_front();
        check_value(name, "data", beat[31:0], result_data);
        check_value(name, "mask", 32'(beat[35:32]), 32'(result_mask));
        check_value(name, "vd", 32'(beat[40:36]), 32'(result_vd));
        check_value(name, "illegal", 32'(beat[41]), 32'(result_illegal));
      end
      if (in_credit) begin
        up_credits++;
      end
      out_credits = out_credits + int'(result_credit) - int'(result_valid);
    end
  end

  initial begin
    int op_i;
    int form_i;
    reset = 1'b1;
    instr_valid = 1'b0;
    instr = '0;
    vs1_data = '0;
    vs2_data = '0;
    rs1_data = '0;
    result_credit = 1'b0;
    credit_on = 1'b0;
    up_credits = `VLU_IN_CREDITS;
    shadow_code = 2;
    lfsr = 32'd80575;
    repeat (8) tick();
    reset = 1'b0;

    // fill the queue while the downstream gives no credit
    for (int k = 0; k < `VLU_IN_CREDITS; k++) begin
      run_op("held vadd.vv", arith_word(vector_isa_pkg::F6_VADD, 1'b1,
                                        vector_isa_pkg::OPIVV, rand_bits(5)));
    end
    repeat (20) tick();
    credit_on = 1'b1;

    // every op and form at each SEW
    for (int s = 0; s < 3; s++) begin
      run_op($sformatf("vsetvli sew%0d", 8 << s), cfg_word(1'b0, 3'(s)));
      for (int oi = 0; oi < 17; oi++) begin
        for (int fi = 0; fi < 3; fi++) begin
          run_op($sformatf("%s.%s sew%0d", op_names[oi], form_names[fi], 8 << s),
                 arith_word(op_f6[oi], 1'b1, form_f3[fi], rand_bits(5)));
        end
      end
    end

    // narrow SEW first so a wrongly taken vsew shows in the next add
    run_op("vsetvli sew8 before bad one", cfg_word(1'b0, 3'd0));
    run_op("vsetvli sew64", cfg_word(1'b0, 3'd3));
    run_op("vadd.vi after bad vsetvli", arith_word(vector_isa_pkg::F6_VADD, 1'b1,
                                                   vector_isa_pkg::OPIVI, 5'h1f));
    run_op("vsetvl form", cfg_word(1'b1, 3'd0));
    run_op("vadd.vv vm=0", arith_word(vector_isa_pkg::F6_VADD, 1'b0,
                                      vector_isa_pkg::OPIVV, 5'd3));
    run_op("opm funct3", arith_word(vector_isa_pkg::F6_VADD, 1'b1,
                                    vector_isa_pkg::OPMVV, 5'd3));
    run_op("opm vx funct3", arith_word(vector_isa_pkg::F6_VADD, 1'b1,
                                       vector_isa_pkg::OPMVX, 5'd3));
    run_op("non-vector opcode", {25'h0123456, 7'b0110011});

    for (int k = 0; k < 80; k++) begin
      if (rand_bits(3) == 0) begin
        run_op("random vsetvli", cfg_word(1'b0, 3'(rand_bits(2))));
      end else begin
        op_i = rand_bits(5) % 17;
        form_i = rand_bits(2) % 3;
        run_op($sformatf("random %s.%s", op_names[op_i], form_names[form_i]),
               arith_word(op_f6[op_i], rand_bits(3) != 0, form_f3[form_i], rand_bits(5)));
      end
    end

    drain();
    // a few idle cycles to catch a stray result beat
    repeat (10) tick();
    $display("All checks passed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== hdl/vector_lane_unit.sv ====
`default_nettype none
`include "vector_macros.svh"

module vector_lane_unit (
  input wire logic                     clk,
  input wire logic                     reset,
  input wire logic                     instr_valid,
  input wire logic [`VLU_INSTR_W-1:0]  instr,
  input wire logic [`VLU_XLEN-1:0]     vs1_data,
  input wire logic [`VLU_XLEN-1:0]     vs2_data,
  input wire logic [`VLU_XLEN-1:0]     rs1_data,
  input wire logic                     result_credit,
  output logic                         in_credit,
  output logic                         result_valid,
  output logic [`VLU_XLEN-1:0]         result_data,
  output logic [`VLU_ELEMS_MAX-1:0]    result_mask,
  output logic [4:0]                   result_vd,
  output logic                         result_illegal
);

  exec_req_if req_bus ();
  result_if   res_bus ();

  // decode -> execute -> result queue
  vector_decode u_decode (
    .clk         (clk),
    .reset       (reset),
    .instr_valid (instr_valid),
    .instr       (instr),
    .vs1_data    (vs1_data),
    .vs2_data    (vs2_data),
    .rs1_data    (rs1_data),
    .req         (req_bus.decode)
  );

  vector_execute u_execute (
    .clk   (clk),
    .reset (reset),
    .req   (req_bus.execute),
    .res   (res_bus.execute)
  );

  vector_result u_result (
    .clk            (clk),
    .reset          (reset),
    .res            (res_bus.result),
    .result_credit  (result_credit),
    .in_credit      (in_credit),
    .result_valid   (result_valid),
    .result_data    (result_data),
    .result_mask    (result_mask),
    .result_vd      (result_vd),
    .result_illegal (result_illegal)
  );

endmodule

`default_nettype wire

// ==== hdl/vector_result.sv ====
`default_nettype none
`include "vector_macros.svh"

module vector_result (
  input wire logic                  clk,
  input wire logic                  reset,
  result_if.result                  res,
  input wire logic                  result_credit,
  output logic                      in_credit,
  output logic                      result_valid,
  output logic [`VLU_XLEN-1:0]      result_data,
  output logic [`VLU_ELEMS_MAX-1:0] result_mask,
  output logic [4:0]                result_vd,
  output logic                      result_illegal
);

  logic [`VLU_XLEN-1:0]      data_q [`VLU_IN_CREDITS];
  logic [`VLU_ELEMS_MAX-1:0] mask_q [`VLU_IN_CREDITS];
  logic [4:0]                vd_q   [`VLU_IN_CREDITS];
  logic                      ill_q  [`VLU_IN_CREDITS];
  logic [`VLU_QPTR_W-1:0]    wr_ptr;
  logic [`VLU_QPTR_W-1:0]    rd_ptr;
  logic [`VLU_QCNT_W-1:0]    count;
  logic [`VLU_CREDIT_W-1:0]  credits;
  logic                      pop;

  // a credit arriving this cycle can be spent right away
  assign pop = (count != '0) && ((credits != '0) || result_credit);

  assign result_valid   = pop;
  assign in_credit      = pop;
  assign result_data    = data_q[rd_ptr];
  assign result_mask    = mask_q[rd_ptr];
  assign result_vd      = vd_q[rd_ptr];
  assign result_illegal = ill_q[rd_ptr];

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      count   <= '0;
      credits <= '0;
    end else begin
      if (res.valid) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      count   <= count + `VLU_QCNT_W'(res.valid) - `VLU_QCNT_W'(pop);
      credits <= credits + `VLU_CREDIT_W'(result_credit) - `VLU_CREDIT_W'(pop);
    end
  end

  // queue storage, never full since upstream holds only as many credits
  always_ff @(posedge clk) begin
    if (res.valid) begin
      data_q[wr_ptr] <= res.data;
      mask_q[wr_ptr] <= res.mask;
      vd_q[wr_ptr]   <= res.vd;
      ill_q[wr_ptr]  <= res.illegal;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/vector_execute.sv ====
`default_nettype none
`include "vector_macros.svh"

module vector_execute (
  input wire logic clk,
  input wire logic reset,
  exec_req_if.execute req,
  result_if.execute   res
);

  logic [`VLU_XLEN-1:0]      elem_res [`VLU_ELEMS_MAX];
  logic [`VLU_ELEMS_MAX-1:0] cmp_bits;
  logic [`VLU_ELEMS_MAX-1:0] elem_en;
  logic [`VLU_XLEN-1:0]      packed_data;
  logic [4:0]                sh_mask;

  // element idx of v, extended to 33 bits so one signed compare covers both kinds
  function automatic logic [`VLU_XLEN:0] elem_ext(input logic [`VLU_XLEN-1:0] v,
                                                  input int idx,
                                                  input logic [`VLU_SEW_W-1:0] sew,
                                                  input logic sgn);
    logic [7:0]  e8;
    logic [15:0] e16;
    e8  = v[8*idx +: 8];
    e16 = v[16*(idx%2) +: 16];
    case (sew)
      vector_exec_pkg::SEW8:  elem_ext = {{25{sgn & e8[7]}}, e8};
      vector_exec_pkg::SEW16: elem_ext = {{17{sgn & e16[15]}}, e16};
      default:                elem_ext = {sgn & v[`VLU_XLEN-1], v};
    endcase
  endfunction

  // shift amount keeps log2(SEW) bits
  assign sh_mask = {req.sew == vector_exec_pkg::SEW32, req.sew != vector_exec_pkg::SEW8, 3'b111};

  always_comb begin
    logic [`VLU_XLEN:0] a_e;
    logic [`VLU_XLEN:0] b_e;
    logic [`VLU_XLEN:0] shr;
    logic [4:0]         sh;
    for (int i = 0; i < `VLU_ELEMS_MAX; i++) begin
      a_e = elem_ext(req.op_a, i, req.sew, req.is_signed);
      b_e = elem_ext(req.op_b, i, req.sew, req.is_signed);
      sh  = a_e[4:0] & sh_mask;
      shr = '0;
      elem_res[i] = '0;
      cmp_bits[i] = 1'b0;
      case (req.alu_op)
        vector_exec_pkg::ALU_ADD:  elem_res[i] = b_e[`VLU_XLEN-1:0] + a_e[`VLU_XLEN-1:0];
        vector_exec_pkg::ALU_SUB:  elem_res[i] = b_e[`VLU_XLEN-1:0] - a_e[`VLU_XLEN-1:0];
        vector_exec_pkg::ALU_RSUB: elem_res[i] = a_e[`VLU_XLEN-1:0] - b_e[`VLU_XLEN-1:0];
        vector_exec_pkg::ALU_AND:  elem_res[i] = b_e[`VLU_XLEN-1:0] & a_e[`VLU_XLEN-1:0];
        vector_exec_pkg::ALU_OR:   elem_res[i] = b_e[`VLU_XLEN-1:0] | a_e[`VLU_XLEN-1:0];
        vector_exec_pkg::ALU_XOR:  elem_res[i] = b_e[`VLU_XLEN-1:0] ^ a_e[`VLU_XLEN-1:0];
        vector_exec_pkg::ALU_MIN: begin
          elem_res[i] = ($signed(a_e) < $signed(b_e)) ? a_e[`VLU_XLEN-1:0] : b_e[`VLU_XLEN-1:0];
        end
        vector_exec_pkg::ALU_MAX: begin
          elem_res[i] = ($signed(a_e) > $signed(b_e)) ? a_e[`VLU_XLEN-1:0] : b_e[`VLU_XLEN-1:0];
        end
        vector_exec_pkg::ALU_CMP: begin
          case (req.cmp_code)
            vector_exec_pkg::CMP_EQ: cmp_bits[i] = (b_e == a_e);
            vector_exec_pkg::CMP_NE: cmp_bits[i] = (b_e != a_e);
            default:                 cmp_bits[i] = ($signed(b_e) < $signed(a_e));
          endcase
        end
        vector_exec_pkg::ALU_SLL: elem_res[i] = b_e[`VLU_XLEN-1:0] << sh;
        vector_exec_pkg::ALU_SRL: begin
          shr = b_e >> sh;
          elem_res[i] = shr[`VLU_XLEN-1:0];
        end
        vector_exec_pkg::ALU_SRA: begin
          shr = $signed(b_e) >>> sh;
          elem_res[i] = shr[`VLU_XLEN-1:0];
        end
        default: elem_res[i] = '0;
      endcase
    end
  end

  // gather element results back into the slice
  always_comb begin
    case (req.sew)
      vector_exec_pkg::SEW8: begin
        packed_data = {elem_res[3][7:0], elem_res[2][7:0], elem_res[1][7:0], elem_res[0][7:0]};
        elem_en     = 4'b1111;
      end
      vector_exec_pkg::SEW16: begin
        packed_data = {elem_res[1][15:0], elem_res[0][15:0]};
        elem_en     = 4'b0011;
      end
      default: begin
        packed_data = elem_res[0];
        elem_en     = 4'b0001;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      res.valid <= 1'b0;
    end else begin
      res.valid <= req.valid;
    end
  end

  always_ff @(posedge clk) begin
    res.vd      <= req.vd;
    res.illegal <= req.illegal;
    res.data    <= '0;
    res.mask    <= '0;
    if (!req.illegal) begin
      if (req.alu_op == vector_exec_pkg::ALU_CMP) begin
        res.mask <= cmp_bits & elem_en;
      end else if (req.alu_op == vector_exec_pkg::ALU_CFG) begin
        res.data <= `VLU_XLEN'(req.cfg_value);
      end else begin
        res.data <= packed_data;
      end
    end
  end

endmodule

`default_nettype wire

// ==== hdl/vector_decode.sv ====
`default_nettype none
`include "vector_macros.svh"

module vector_decode (
  input wire logic                    clk,
  input wire logic                    reset,
  input wire logic                    instr_valid,
  input wire vector_isa_pkg::vinstr_u instr,
  input wire logic [`VLU_XLEN-1:0]    vs1_data,
  input wire logic [`VLU_XLEN-1:0]    vs2_data,
  input wire logic [`VLU_XLEN-1:0]    rs1_data,
  exec_req_if.decode                  req
);

  logic [`VLU_SEW_W-1:0]    vtype_sew;
  logic [`VLU_ALU_OP_W-1:0] alu_op;
  logic [`VLU_CMP_W-1:0]    cmp_code;
  logic                     is_signed;
  logic                     known_op;
  logic                     no_vv;
  logic                     no_vi;
  logic                     is_shift;
  logic                     is_opi;
  logic                     opi_ok;
  logic                     cfg_ok;
  logic [2:0]               vsew;
  logic [`VLU_XLEN-1:0]     imm;
  logic [`VLU_XLEN-1:0]     scalar;
  logic [`VLU_XLEN-1:0]     op_a;

  // scalar replicated into every element of the slice
  function automatic logic [`VLU_XLEN-1:0] splat(input logic [`VLU_XLEN-1:0] s,
                                                 input logic [`VLU_SEW_W-1:0] sew);
    case (sew)
      vector_exec_pkg::SEW8:  splat = {4{s[7:0]}};
      vector_exec_pkg::SEW16: splat = {2{s[15:0]}};
      default:                splat = s;
    endcase
  endfunction

  // funct6 to ALU op, plus forms that do not exist
  always_comb begin
    alu_op    = vector_exec_pkg::ALU_ADD;
    cmp_code  = vector_exec_pkg::CMP_EQ;
    is_signed = vector_exec_pkg::UNSIGNED_OP;
    known_op  = 1'b1;
    no_vv     = 1'b0;
    no_vi     = 1'b0;
    is_shift  = 1'b0;
    case (instr.arith.funct6)
      vector_isa_pkg::F6_VADD:  alu_op = vector_exec_pkg::ALU_ADD;
      vector_isa_pkg::F6_VSUB: begin
        alu_op = vector_exec_pkg::ALU_SUB;
        no_vi  = 1'b1;
      end
      vector_isa_pkg::F6_VRSUB: begin
        alu_op = vector_exec_pkg::ALU_RSUB;
        no_vv  = 1'b1;
      end
      vector_isa_pkg::F6_VMINU, vector_isa_pkg::F6_VMIN: begin
        alu_op    = vector_exec_pkg::ALU_MIN;
        is_signed = instr.arith.funct6[0];
        no_vi     = 1'b1;
      end
      vector_isa_pkg::F6_VMAXU, vector_isa_pkg::F6_VMAX: begin
        alu_op    = vector_exec_pkg::ALU_MAX;
        is_signed = instr.arith.funct6[0];
        no_vi     = 1'b1;
      end
      vector_isa_pkg::F6_VAND:  alu_op = vector_exec_pkg::ALU_AND;
      vector_isa_pkg::F6_VOR:   alu_op = vector_exec_pkg::ALU_OR;
      vector_isa_pkg::F6_VXOR:  alu_op = vector_exec_pkg::ALU_XOR;
      vector_isa_pkg::F6_VMSEQ: alu_op = vector_exec_pkg::ALU_CMP;
      vector_isa_pkg::F6_VMSNE: begin
        alu_op   = vector_exec_pkg::ALU_CMP;
        cmp_code = vector_exec_pkg::CMP_NE;
      end
      vector_isa_pkg::F6_VMSLTU, vector_isa_pkg::F6_VMSLT: begin
        alu_op    = vector_exec_pkg::ALU_CMP;
        cmp_code  = vector_exec_pkg::CMP_LT;
        is_signed = instr.arith.funct6[0];
        no_vi     = 1'b1;
      end
      vector_isa_pkg::F6_VSLL: begin
        alu_op   = vector_exec_pkg::ALU_SLL;
        is_shift = 1'b1;
      end
      vector_isa_pkg::F6_VSRL: begin
        alu_op   = vector_exec_pkg::ALU_SRL;
        is_shift = 1'b1;
      end
      vector_isa_pkg::F6_VSRA: begin
        alu_op    = vector_exec_pkg::ALU_SRA;
        is_signed = vector_exec_pkg::SIGNED_OP;
        is_shift  = 1'b1;
      end
      default: known_op = 1'b0;
    endcase
  end

  assign is_opi = (instr.arith.funct3 == vector_isa_pkg::OPIVV) ||
                  (instr.arith.funct3 == vector_isa_pkg::OPIVX) ||
                  (instr.arith.funct3 == vector_isa_pkg::OPIVI);

  // masked forms are not supported, vm must be set
  assign opi_ok = (instr.arith.opcode == vector_isa_pkg::OP_VECTOR) && is_opi &&
                  instr.arith.vm && known_op &&
                  !(no_vv && (instr.arith.funct3 == vector_isa_pkg::OPIVV)) &&
                  !(no_vi && (instr.arith.funct3 == vector_isa_pkg::OPIVI));

  // vsetvli only; vsew above 32 is rejected
  assign vsew   = instr.cfg.zimm11[5:3];
  assign cfg_ok = (instr.cfg.opcode == vector_isa_pkg::OP_VECTOR) &&
                  (instr.cfg.funct3 == vector_isa_pkg::OPCFG) &&
                  !instr.cfg.sel && (vsew <= 3'd2);

  // shifts take the immediate unsigned
  assign imm = is_shift ? {{(`VLU_XLEN-5){1'b0}}, instr.arith.vs1}
                        : {{(`VLU_XLEN-5){instr.arith.vs1[4]}}, instr.arith.vs1};

  assign scalar = (instr.arith.funct3 == vector_isa_pkg::OPIVI) ? imm : rs1_data;
  assign op_a   = (instr.arith.funct3 == vector_isa_pkg::OPIVV) ? vs1_data
                                                                : splat(scalar, vtype_sew);

  always_ff @(posedge clk) begin
    if (reset) begin
      req.valid <= 1'b0;
      vtype_sew <= vector_exec_pkg::SEW32;
    end else begin
      req.valid <= instr_valid;
      if (instr_valid && cfg_ok) begin
        vtype_sew <= vsew[`VLU_SEW_W-1:0];
      end
    end
  end

  always_ff @(posedge clk) begin
    req.alu_op    <= cfg_ok ? vector_exec_pkg::ALU_CFG : alu_op;
    req.is_signed <= is_signed;
    req.cmp_code  <= cmp_code;
    req.sew       <= vtype_sew;
    req.op_a      <= op_a;
    req.op_b      <= vs2_data;
    req.vd        <= instr.arith.vd;
    req.illegal   <= !(opi_ok || cfg_ok);
    req.cfg_value <= vsew[`VLU_SEW_W-1:0];
  end

endmodule

`default_nettype wire

// ==== hdl/vector_stage_if.sv ====
`default_nettype none
`include "vector_macros.svh"

// decoded request, one cycle per beat
interface exec_req_if;
  logic                     valid;
  logic [`VLU_ALU_OP_W-1:0] alu_op;
  logic                     is_signed;
  logic [`VLU_CMP_W-1:0]    cmp_code;
  logic [`VLU_SEW_W-1:0]    sew;
  logic [`VLU_XLEN-1:0]     op_a;
  logic [`VLU_XLEN-1:0]     op_b;
  logic [4:0]               vd;
  logic                     illegal;
  logic [`VLU_SEW_W-1:0]    cfg_value;

  modport decode (
    output valid, alu_op, is_signed, cmp_code, sew,
    output op_a, op_b, vd, illegal, cfg_value
  );
  modport execute (
    input valid, alu_op, is_signed, cmp_code, sew,
    input op_a, op_b, vd, illegal, cfg_value
  );
endinterface

// executed result heading for the output queue
interface result_if;
  logic                      valid;
  logic [`VLU_XLEN-1:0]      data;
  logic [`VLU_ELEMS_MAX-1:0] mask;
  logic [4:0]                vd;
  logic                      illegal;

  modport execute (
    output valid, data, mask, vd, illegal
  );
  modport result (
    input valid, data, mask, vd, illegal
  );
endinterface

`default_nettype wire

// ==== hdl/vector_exec_pkg.sv ====
`default_nettype none
`include "vector_macros.svh"

package vector_exec_pkg;

  // element ALU operations
  localparam logic [`VLU_ALU_OP_W-1:0] ALU_ADD  = 4'd0;
  localparam logic [`VLU_ALU_OP_W-1:0] ALU_SUB  = 4'd1;
  localparam logic [`VLU_ALU_OP_W-1:0] ALU_RSUB = 4'd2;
  localparam logic [`VLU_ALU_OP_W-1:0] ALU_AND  = 4'd3;
  localparam logic [`VLU_ALU_OP_W-1:0] ALU_OR   = 4'd4;
  localparam logic [`VLU_ALU_OP_W-1:0] ALU_XOR  = 4'd5;
  localparam logic [`VLU_ALU_OP_W-1:0] ALU_MIN  = 4'd6;
  localparam logic [`VLU_ALU_OP_W-1:0] ALU_MAX  = 4'd7;
  localparam logic [`VLU_ALU_OP_W-1:0] ALU_CMP  = 4'd8;
  localparam logic [`VLU_ALU_OP_W-1:0] ALU_SLL  = 4'd9;
  localparam logic [`VLU_ALU_OP_W-1:0] ALU_SRL  = 4'd10;
  localparam logic [`VLU_ALU_OP_W-1:0] ALU_SRA  = 4'd11;
  localparam logic [`VLU_ALU_OP_W-1:0] ALU_CFG  = 4'd12;

  // operand extension
  localparam logic SIGNED_OP   = 1'b1;
  localparam logic UNSIGNED_OP = 1'b0;

  // compare sub-ops, signedness comes from the flag above
  localparam logic [`VLU_CMP_W-1:0] CMP_EQ = 2'd0;
  localparam logic [`VLU_CMP_W-1:0] CMP_NE = 2'd1;
  localparam logic [`VLU_CMP_W-1:0] CMP_LT = 2'd2;

  // element width, same code as vsew in vtype
  localparam logic [`VLU_SEW_W-1:0] SEW8  = 2'd0;
  localparam logic [`VLU_SEW_W-1:0] SEW16 = 2'd1;
  localparam logic [`VLU_SEW_W-1:0] SEW32 = 2'd2;

endpackage

`default_nettype wire

// ==== hdl/vector_isa_pkg.sv ====
`default_nettype none

package vector_isa_pkg;

  // arithmetic view and vsetvli view of the same word
  typedef union packed {
    struct packed {
      logic [5:0] funct6;
      logic       vm;
      logic [4:0] vs2;
      logic [4:0] vs1;
      logic [2:0] funct3;
      logic [4:0] vd;
      logic [6:0] opcode;
    } arith;
    struct packed {
      logic        sel;
      logic [10:0] zimm11;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } cfg;
  } vinstr_u;

  localparam logic [6:0] OP_VECTOR = 7'b1010111;

  // funct3 major forms
  localparam logic [2:0] OPIVV = 3'b000;
  localparam logic [2:0] OPMVV = 3'b010;
  localparam logic [2:0] OPIVI = 3'b011;
  localparam logic [2:0] OPIVX = 3'b100;
  localparam logic [2:0] OPMVX = 3'b110;
  localparam logic [2:0] OPCFG = 3'b111;

  // funct6 of the OPI integer ops
  localparam logic [5:0] F6_VADD  = 6'b000000;
  localparam logic [5:0] F6_VSUB  = 6'b000010;
  localparam logic [5:0] F6_VRSUB = 6'b000011;
  localparam logic [5:0] F6_VMINU = 6'b000100;
  localparam logic [5:0] F6_VMIN  = 6'b000101;
  localparam logic [5:0] F6_VMAXU = 6'b000110;
  localparam logic [5:0] F6_VMAX  = 6'b000111;
  localparam logic [5:0] F6_VAND  = 6'b001001;
  localparam logic [5:0] F6_VOR   = 6'b001010;
  localparam logic [5:0] F6_VXOR  = 6'b001011;
  localparam logic [5:0] F6_VMSEQ  = 6'b011000;
  localparam logic [5:0] F6_VMSNE  = 6'b011001;
  localparam logic [5:0] F6_VMSLTU = 6'b011010;
  localparam logic [5:0] F6_VMSLT  = 6'b011011;
  localparam logic [5:0] F6_VSLL  = 6'b100101;
  localparam logic [5:0] F6_VSRL  = 6'b101000;
  localparam logic [5:0] F6_VSRA  = 6'b101001;

endpackage

`default_nettype wire

// ==== hdl/vector_macros.svh ====
`ifndef VECTOR_MACROS_SVH
`define VECTOR_MACROS_SVH

// slice, scalar and instruction widths
`define VLU_XLEN 32
`define VLU_INSTR_W 32
`define VLU_ELEMS_MAX 4

// input credits double as result queue depth
`define VLU_IN_CREDITS 4
`define VLU_CREDIT_W 4
`define VLU_QPTR_W 2
`define VLU_QCNT_W 3

// decoded control field widths
`define VLU_ALU_OP_W 4
`define VLU_CMP_W 2
`define VLU_SEW_W 2

`endif
